//--- verilog/rs_enc_pkg.sv
package rs_enc_pkg;

    localparam int SYM_W    = 8;
    localparam int K_SYM    = 168;               // Message symbols
    localparam int NSYM_DEF = 32;                // Parity symbols
    localparam int N_SYM    = K_SYM + NSYM_DEF;  // Codeword length, at most 255

    // x^8 + x^4 + x^3 + x^2 + 1
    localparam logic [SYM_W:0] GF_POLY = 9'h11D;

    typedef logic [SYM_W-1:0] sym_t;

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_MSG,
        PH_PARITY,
        PH_FINISH
    } enc_phase_t;

    // Shift-and-add multiply with reduction by GF_POLY
    function automatic sym_t gf_mul(input sym_t a, input sym_t b);
        sym_t acc;
        sym_t sh;
        acc = '0;
        sh  = a;
        for (int i = 0; i < SYM_W; i++) begin
            if (b[i]) begin
                acc = acc ^ sh;
            end
            if (sh[SYM_W-1]) begin
                sh = (sh << 1) ^ GF_POLY[SYM_W-1:0];
            end else begin
                sh = sh << 1;
            end
        end
        return acc;
    endfunction

    // Coefficient of x^idx in prod (x - alpha^i), i = 0 .. nsym-1
    // The leading x^nsym term is 1 and is never asked for
    function automatic sym_t rs_gen_coeff(input int nsym, input int idx);
        sym_t g [256];
        sym_t root;
        for (int j = 0; j < 256; j++) begin
            g[j] = '0;
        end
        g[0] = 8'h01;
        root = 8'h01;                            // alpha^0
        for (int i = 0; i < 255; i++) begin
            if (i < nsym) begin
                // Multiply running product by (x + root)
                for (int j = 255; j > 0; j--) begin
                    if (j <= i + 1) begin
                        g[j] = g[j-1] ^ gf_mul(g[j], root);
                    end
                end
                g[0] = gf_mul(g[0], root);
                root = gf_mul(root, 8'h02);      // Next power of alpha
            end
        end
        return g[idx];
    endfunction

endpackage

//--- verilog/rs_msg_serializer.sv
`timescale 1ns/100ps

module rs_msg_serializer
    import rs_enc_pkg::*;
#(
    parameter int K    = K_SYM,
    parameter int NSYM = NSYM_DEF
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             clrn,
    input  logic             encode_en,
    input  logic [K*SYM_W-1:0] datain,
    output logic             ready,
    output logic             valid,
    output logic             msg_valid,
    output logic             par_shift,
    output sym_t             msg_sym
);

    localparam int CNT_W = $clog2(K + NSYM);

    enc_phase_t         phase;
    logic [CNT_W-1:0]   cnt;
    logic [K*SYM_W-1:0] msg_q;
    logic               accept;

    assign accept  = encode_en && ready;
    assign msg_sym = msg_q[SYM_W-1:0];      // Symbol 0 goes first

    // Message holding register, shifted down one symbol per message cycle
    always_ff @(posedge clk) begin
        if (accept && phase == PH_IDLE) begin
            msg_q <= datain;
        end else if (msg_valid) begin
            msg_q <= {{SYM_W{1'b0}}, msg_q[K*SYM_W-1:SYM_W]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase     <= PH_IDLE;
            cnt       <= '0;
            ready     <= 1'b1;
            valid     <= 1'b0;
            msg_valid <= 1'b0;
            par_shift <= 1'b0;
        end else if (!clrn) begin
            // Abandon any codeword in flight
            phase     <= PH_IDLE;
            cnt       <= '0;
            ready     <= 1'b1;
            valid     <= 1'b0;
            msg_valid <= 1'b0;
            par_shift <= 1'b0;
        end else begin
            valid <= 1'b0;
            case (phase)
                PH_IDLE: begin
                    if (accept) begin
                        ready     <= 1'b0;
                        msg_valid <= 1'b1;
                        cnt       <= '0;
                        phase     <= PH_MSG;
                    end
                end

                PH_MSG: begin
                    if (cnt == CNT_W'(K - 1)) begin
                        msg_valid <= 1'b0;
                        par_shift <= 1'b1;   // Parity follows straight on
                        cnt       <= '0;
                        phase     <= PH_PARITY;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end

                PH_PARITY: begin
                    if (cnt == CNT_W'(NSYM - 1)) begin
                        par_shift <= 1'b0;
                        cnt       <= '0;
                        phase     <= PH_FINISH;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end

                PH_FINISH: begin
                    valid <= 1'b1;           // Single cycle strobe
                    ready <= 1'b1;
                    phase <= PH_IDLE;
                end

                default: phase <= PH_IDLE;
            endcase
        end
    end

endmodule

//--- verilog/rs_parity_lfsr.sv
`timescale 1ns/100ps

module rs_parity_lfsr
    import rs_enc_pkg::*;
#(
    parameter int NSYM = NSYM_DEF
) (
    input  logic clk,
    input  logic rst_n,
    input  logic clrn,
    input  logic msg_valid,
    input  logic par_shift,
    input  sym_t msg_sym,
    output sym_t par_sym
);

    sym_t par_q [NSYM];   // par_q[i] holds remainder coefficient of x^i
    sym_t prod  [NSYM];
    sym_t fb;

    assign par_sym = par_q[NSYM-1];
    assign fb      = msg_sym ^ par_q[NSYM-1];

    // Constant multipliers, one per generator tap
    for (genvar i = 0; i < NSYM; i++) begin : g_tap
        localparam sym_t COEF = rs_gen_coeff(NSYM, i);
        assign prod[i] = gf_mul(fb, COEF);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int j = 0; j < NSYM; j++) begin
                par_q[j] <= '0;
            end
        end else if (!clrn) begin
            for (int j = 0; j < NSYM; j++) begin
                par_q[j] <= '0;
            end
        end else if (msg_valid) begin
            // Division step
            par_q[0] <= prod[0];
            for (int j = 1; j < NSYM; j++) begin
                par_q[j] <= par_q[j-1] ^ prod[j];
            end
        end else if (par_shift) begin
            // Unload remainder, zeros follow in behind
            par_q[0] <= '0;
            for (int j = 1; j < NSYM; j++) begin
                par_q[j] <= par_q[j-1];
            end
        end
    end

endmodule

//--- verilog/rs_codeword_buffer.sv
`timescale 1ns/100ps

module rs_codeword_buffer
    import rs_enc_pkg::*;
#(
    parameter int K    = K_SYM,
    parameter int NSYM = NSYM_DEF
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        clrn,
    input  logic                        msg_valid,
    input  logic                        par_shift,
    input  sym_t                        msg_sym,
    input  sym_t                        par_sym,
    output logic [(K+NSYM)*SYM_W-1:0]   encoded_data
);

    localparam int N = K + NSYM;

    sym_t in_sym;
    logic shift_en;

    assign shift_en = msg_valid || par_shift;
    assign in_sym   = msg_valid ? msg_sym : par_sym;

    // New symbol enters at the top and walks down
    // After N strobes the first symbol sits at position 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            encoded_data <= '0;
        end else if (!clrn) begin
            encoded_data <= '0;
        end else if (shift_en) begin
            encoded_data <= {in_sym, encoded_data[N*SYM_W-1:SYM_W]};
        end
    end

endmodule

//--- verilog/rs_encode_top.sv
`timescale 1ns/100ps

module rs_encode_top
    import rs_enc_pkg::*;
#(
    parameter int K    = K_SYM,
    parameter int NSYM = NSYM_DEF
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      clrn,          // Synchronous abort
    input  logic                      encode_en,
    input  logic [K*SYM_W-1:0]        datain,
    output logic [(K+NSYM)*SYM_W-1:0] encoded_data,
    output logic                      valid,
    output logic                      ready
);

    logic msg_valid;
    logic par_shift;
    sym_t msg_sym;
    sym_t par_sym;

    rs_msg_serializer #(
        .K    (K),
        .NSYM (NSYM)
    ) u_serializer (
        .clk       (clk),
        .rst_n     (rst_n),
        .clrn      (clrn),
        .encode_en (encode_en),
        .datain    (datain),
        .ready     (ready),
        .valid     (valid),
        .msg_valid (msg_valid),
        .par_shift (par_shift),
        .msg_sym   (msg_sym)
    );

    rs_parity_lfsr #(
        .NSYM (NSYM)
    ) u_lfsr (
        .clk       (clk),
        .rst_n     (rst_n),
        .clrn      (clrn),
        .msg_valid (msg_valid),
        .par_shift (par_shift),
        .msg_sym   (msg_sym),
        .par_sym   (par_sym)
    );

    // Collects message then parity
    rs_codeword_buffer #(
        .K    (K),
        .NSYM (NSYM)
    ) u_buffer (
        .clk          (clk),
        .rst_n        (rst_n),
        .clrn         (clrn),
        .msg_valid    (msg_valid),
        .par_shift    (par_shift),
        .msg_sym      (msg_sym),
        .par_sym      (par_sym),
        .encoded_data (encoded_data)
    );

endmodule

//--- dv/rs_tb_clkgen.sv
`timescale 1ns/100ps

module rs_tb_clkgen #(
    parameter int PERIOD_NS  = 10,
    parameter int RST_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;                     // Released off the edge like other inputs
    end

endmodule

//--- dv/rs_encode_checker.sv
`timescale 1ns/100ps

module rs_encode_checker
    import rs_enc_pkg::*;
#(
    parameter int K    = K_SYM,
    parameter int NSYM = NSYM_DEF
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      clrn,
    input  logic                      encode_en,
    input  logic                      ready,
    input  logic                      valid,
    input  logic [K*8-1:0]            datain,
    input  logic [(K+NSYM)*8-1:0]     encoded_data,
    output int                        value_errs,
    output int                        protocol_errs,
    output int                        done_cnt
);

    localparam int N = K + NSYM;

    logic [7:0]     gen [NSYM+1];            // gen[j] is the coefficient of x^j
    logic [N*8-1:0] exp_cw;
    logic           pending;
    logic           at_done;
    logic           exp_ready;
    int             age;
    int             n_value = 0;
    int             n_proto = 0;
    int             n_done  = 0;

    assign value_errs    = n_value;
    assign protocol_errs = n_proto;
    assign done_cnt      = n_done;

    // Carry-less product, then fold the high bits back with 0x11D
    function automatic logic [7:0] field_mult(input logic [7:0] a, input logic [7:0] b);
        logic [14:0] p;
        p = '0;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                p = p ^ (15'(a) << i);
            end
        end
        for (int i = 14; i >= 8; i--) begin
            if (p[i]) begin
                p = p ^ (15'h11D << (i - 8));
            end
        end
        return p[7:0];
    endfunction

    initial begin
        logic [7:0] root;
        for (int j = 0; j <= NSYM; j++) begin
            gen[j] = 8'h00;
        end
        gen[0] = 8'h01;
        root   = 8'h01;
        for (int i = 0; i < NSYM; i++) begin
            for (int j = i + 1; j > 0; j--) begin
                gen[j] = gen[j-1] ^ field_mult(gen[j], root);
            end
            gen[0] = field_mult(gen[0], root);
            root   = field_mult(root, 8'h02);
        end
    end

    // Long division of msg * x^NSYM by the generator, leading symbol first
    function automatic logic [N*8-1:0] encode_model(input logic [K*8-1:0] msg);
        logic [7:0]     w [N];
        logic [7:0]     c;
        logic [N*8-1:0] cw;
        for (int i = 0; i < N; i++) begin
            w[i] = (i < K) ? msg[i*8 +: 8] : 8'h00;
        end
        for (int i = 0; i < K; i++) begin
            c = w[i];
            for (int j = 1; j <= NSYM; j++) begin
                w[i+j] = w[i+j] ^ field_mult(gen[NSYM-j], c);
            end
        end
        cw = '0;
        for (int i = 0; i < N; i++) begin
            cw[i*8 +: 8] = (i < K) ? msg[i*8 +: 8] : w[i];
        end
        return cw;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending = 1'b0;
            age     = 0;
        end else begin
            if (pending) begin
                age++;
            end
            at_done = pending && (age == N + 2);
            if (valid === 1'b1) begin
                if (at_done) begin
                    n_done++;
                    for (int s = 0; s < N; s++) begin
                        if (encoded_data[s*8 +: 8] !== exp_cw[s*8 +: 8]) begin
                            n_value++;
                            $display("[ERROR] encoded_data[sym %0d] @%0t: expected %h, got %h",
                                     s, $time, exp_cw[s*8 +: 8], encoded_data[s*8 +: 8]);
                        end
                    end
                end else if (pending) begin
                    n_proto++;
                    $display("Valid pulse came %0d edges after the start instead of %0d (%0t)",
                             age - 1, N + 1, $time);
                end else begin
                    n_proto++;
                    $display("Valid pulse with no codeword in progress at %0t", $time);
                end
            end else if (at_done) begin
                n_proto++;
                $display("Valid pulse missing %0d edges after the start (%0t)", N + 1, $time);
            end
            exp_ready = !(pending && age <= N + 1);
            if (ready !== exp_ready) begin
                n_proto++;
                $display("[ERROR] ready @%0t: expected %h, got %h", $time, exp_ready, ready);
            end
            if (at_done) begin
                pending = 1'b0;
            end
            if (!clrn) begin
                pending = 1'b0;              // Aborted codeword never completes
            end else if (encode_en && ready) begin
                pending = 1'b1;
                age     = 0;
                exp_cw  = encode_model(datain);
            end
        end
    end

endmodule

//--- dv/rs_encode_sva.sv
`timescale 1ns/100ps

module rs_encode_sva (
    input logic clk,
    input logic rst_n,
    input logic clrn,
    input logic encode_en,
    input logic ready,
    input logic valid
);

    int fail_cnt = 0;   // Assertion failures so far

    valid_single: assert property (@(posedge clk) disable iff (!rst_n) valid |=> !valid)
        else begin
            fail_cnt++;
            $error("valid high for more than one cycle");
        end

    // Busy from the accept edge, ready only comes back with valid unless cleared
    busy_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
        (encode_en && ready && clrn) |=> !ready)
        else begin
            fail_cnt++;
            $error("ready still high after a codeword was accepted");
        end

    ready_rise_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
        ($rose(ready) && $past(clrn)) |-> valid)
        else begin
            fail_cnt++;
            $error("ready rose without a valid pulse");
        end

    valid_when_ready: assert property (@(posedge clk) disable iff (!rst_n) valid |-> ready)
        else begin
            fail_cnt++;
            $error("valid seen while ready low");
        end

endmodule

bind rs_encode_top rs_encode_sva u_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .clrn      (clrn),
    .encode_en (encode_en),
    .ready     (ready),
    .valid     (valid)
);

//--- dv/rs_encode_tb.sv
`timescale 1ns/100ps

module rs_encode_tb
    import rs_enc_pkg::*;
();

    localparam int K         = K_SYM;
    localparam int NSYM      = NSYM_DEF;
    localparam int N         = K + NSYM;
    localparam int ROWS      = 12;
    localparam int WD_CYCLES = ROWS * (N + 20) + 100;
    localparam logic [31:0] SEED = 32'h338d_e280;

    typedef enum logic [1:0] {
        MSG_ZERO,
        MSG_UNIT,
        MSG_RAND
    } msg_kind_t;

    typedef struct packed {
        msg_kind_t kind;
        logic      clr_mid;     // Abort with clrn partway through
        logic      b2b;         // encode_en left high into the next row
        logic      poke;        // Extra encode_en while busy
        logic      exp_done;
    } stim_row_t;

    logic               clk;
    logic               rst_n;
    logic               clrn;
    logic               encode_en;
    logic [K*SYM_W-1:0] datain;
    logic [N*SYM_W-1:0] encoded_data;
    logic               valid;
    logic               ready;
    logic [31:0]        lcg_state;
    stim_row_t          stim [ROWS];
    int                 value_errs;
    int                 protocol_errs;
    int                 done_cnt;
    int                 tb_errs;
    int                 assert_errs;
    int                 exp_done_cnt;

    rs_tb_clkgen #(.PERIOD_NS(10), .RST_CYCLES(8)) u_clkgen (.clk(clk), .rst_n(rst_n));

    rs_encode_top #(.K(K), .NSYM(NSYM)) DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .clrn         (clrn),
        .encode_en    (encode_en),
        .datain       (datain),
        .encoded_data (encoded_data),
        .valid        (valid),
        .ready        (ready)
    );

    rs_encode_checker #(.K(K), .NSYM(NSYM)) u_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .clrn          (clrn),
        .encode_en     (encode_en),
        .ready         (ready),
        .valid         (valid),
        .datain        (datain),
        .encoded_data  (encoded_data),
        .value_errs    (value_errs),
        .protocol_errs (protocol_errs),
        .done_cnt      (done_cnt)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic stim_row_t make_row(input msg_kind_t kind, input logic clr_mid,
                                           input logic b2b, input logic poke);
        stim_row_t row;
        row.kind     = kind;
        row.clr_mid  = clr_mid;
        row.b2b      = b2b;
        row.poke     = poke;
        row.exp_done = !clr_mid;
        return row;
    endfunction

    task automatic fill_table();
        stim[0]  = make_row(MSG_ZERO, 1'b0, 1'b0, 1'b0);
        stim[1]  = make_row(MSG_UNIT, 1'b0, 1'b0, 1'b0);
        stim[2]  = make_row(MSG_RAND, 1'b0, 1'b0, 1'b0);
        stim[3]  = make_row(MSG_RAND, 1'b0, 1'b0, 1'b1);
        stim[4]  = make_row(MSG_RAND, 1'b0, 1'b1, 1'b0);
        stim[5]  = make_row(MSG_RAND, 1'b0, 1'b1, 1'b0);
        stim[6]  = make_row(MSG_UNIT, 1'b0, 1'b0, 1'b0);
        stim[7]  = make_row(MSG_RAND, 1'b1, 1'b0, 1'b0);
        stim[8]  = make_row(MSG_RAND, 1'b0, 1'b0, 1'b0);
        stim[9]  = make_row(MSG_ZERO, 1'b0, 1'b0, 1'b1);
        stim[10] = make_row(MSG_UNIT, 1'b1, 1'b0, 1'b0);
        stim[11] = make_row(MSG_RAND, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic build_msg(input msg_kind_t kind, output logic [K*SYM_W-1:0] msg);
        msg = '0;
        if (kind == MSG_UNIT) begin
            msg[(K-1)*SYM_W +: SYM_W] = 8'h01;   // Lowest degree term only
        end else if (kind == MSG_RAND) begin
            for (int s = 0; s < K; s++) begin
                lcg_state = lcg_next(lcg_state);
                msg[s*SYM_W +: SYM_W] = lcg_state[31:24];
            end
        end
    endtask

    task automatic next_slot();
        @(posedge clk);
        #1;
    endtask

    task automatic run_row(input int r);
        logic [K*SYM_W-1:0] msg;
        build_msg(stim[r].kind, msg);
        datain    = msg;
        encode_en = 1'b1;
        while (ready !== 1'b1) begin
            next_slot();
        end
        next_slot();                              // Accept edge
        if (!stim[r].b2b) begin
            encode_en = 1'b0;
        end
        if (stim[r].poke) begin
            repeat (20) next_slot();
            build_msg(MSG_RAND, msg);
            datain    = msg;
            encode_en = 1'b1;
            repeat (4) next_slot();
            encode_en = stim[r].b2b;
        end
        if (stim[r].clr_mid) begin
            repeat (40 + r) next_slot();
            clrn = 1'b0;
            next_slot();
            clrn = 1'b1;
        end else begin
            while (valid !== 1'b1) begin
                next_slot();
            end
        end
    endtask

    initial begin
        clrn         = 1'b1;
        encode_en    = 1'b0;
        datain       = '0;
        lcg_state    = SEED;
        tb_errs      = 0;
        assert_errs  = 0;
        exp_done_cnt = 0;
        fill_table();
        wait (rst_n === 1'b1);
        next_slot();
        for (int r = 0; r < ROWS; r++) begin
            if (r > 0 && !stim[r-1].b2b) begin
                repeat (r % 3) next_slot();
            end
            run_row(r);
            exp_done_cnt += stim[r].exp_done;
        end
        encode_en = 1'b0;
        repeat (4) next_slot();
        if (done_cnt != exp_done_cnt) begin
            tb_errs++;
            $display("Checked %0d codewords but expected %0d to complete",
                     done_cnt, exp_done_cnt);
        end
        assert_errs = DUT.u_sva.fail_cnt;
        $display("Errors: value %0d, protocol %0d, assertion %0d, testbench %0d %s %0d)",
                 value_errs, protocol_errs, assert_errs, tb_errs,
                 "(codewords checked", done_cnt);
        if (value_errs == 0 && protocol_errs == 0 && assert_errs == 0 && tb_errs == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, the stimulus did not finish", WD_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- rs_encode.f
verilog/rs_enc_pkg.sv
verilog/rs_msg_serializer.sv
verilog/rs_parity_lfsr.sv
verilog/rs_codeword_buffer.sv
verilog/rs_encode_top.sv
dv/rs_tb_clkgen.sv
dv/rs_encode_checker.sv
dv/rs_encode_sva.sv
dv/rs_encode_tb.sv

//--- Bender.yml
package:
  name: rs_encode

sources:
  - files:
      - verilog/rs_enc_pkg.sv
      - verilog/rs_msg_serializer.sv
      - verilog/rs_parity_lfsr.sv
      - verilog/rs_codeword_buffer.sv
      - verilog/rs_encode_top.sv
  - target: test
    files:
      - dv/rs_tb_clkgen.sv
      - dv/rs_encode_checker.sv
      - dv/rs_encode_sva.sv
      - dv/rs_encode_tb.sv
